/* all.f */
+incdir+test
common/alu_pkg.sv
common/simd_pkg.sv
simd/simd_lane_ctrl.sv
simd/simd_lane_adder.sv
simd/simd_lane_pack.sv
rtl/scalar_alu.sv
rtl/alu_result_stage.sv
rtl/alu_top.sv
test/tb_alu.sv

/* run.sh */
#!/bin/sh
# Build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_alu -f all.f -o tb_alu_sim

# The simulator exits nonzero on a fatal check, the log decides the result
./obj_dir/tb_alu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
  echo "RESULT: FAIL"
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "RESULT: FAIL (no pass line in sim.log)"
  exit 1
fi
echo "RESULT: PASS"

/* test/tb_alu_tasks.svh */
`ifndef TB_ALU_TASKS_SVH
`define TB_ALU_TASKS_SVH

// ----------------------------------------------------------------------
// Random numbers and checking
// ----------------------------------------------------------------------

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
  end
  return v;
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  if (actual !== expected) begin
    $display("error: %s is %h, expected %h", name, actual, expected);
    $display("tests failed");
    $fatal(1, "mismatch on %s", name);
  end
endtask

// Codes follow the enumeration order of alu_pkg
function automatic alu_op_e op_code(int c);
  return alu_op_e'(c[4:0]);
endfunction

// ----------------------------------------------------------------------
// Reference model
// ----------------------------------------------------------------------
function automatic logic [31:0] model_simd(alu_op_e o, logic [31:0] a, logic [31:0] b);
  int          w;
  int          ea;
  int          eb;
  int          s;
  logic        sub;
  logic        halve;
  logic        sgn;
  logic [31:0] mask;
  logic [31:0] r;
  w     = (o inside {ADD16, SUB16, RADD16, RSUB16, URADD16, URSUB16}) ? 16 : 8;
  sub   = o inside {SUB8, SUB16, RSUB8, RSUB16, URSUB8, URSUB16};
  halve = !(o inside {ADD8, SUB8, ADD16, SUB16});
  sgn   = o inside {RADD8, RSUB8, RADD16, RSUB16};
  mask  = (32'd1 << w) - 32'd1;
  r     = '0;
  for (int p = 0; p < 32; p += w) begin
    ea = int'((a >> p) & mask);
    eb = int'((b >> p) & mask);
    if (sgn && ea[w-1]) ea = ea - (1 << w);
    if (sgn && eb[w-1]) eb = eb - (1 << w);
    // Full sum or difference, halved with its sign kept
    s = sub ? ea - eb : ea + eb;
    if (halve) s = s >>> 1;
    r = r | ((32'(s) & mask) << p);
  end
  return r;
endfunction

function automatic logic [31:0] model_result(alu_op_e o, logic [31:0] a, logic [31:0] b);
  logic [31:0] r;
  r = '0;
  case (o)
    ANDL: r = a & b;
    ORL:  r = a | b;
    XORL: r = a ^ b;
    ANDN: r = a & ~b;
    ORN:  r = a | ~b;
    XNOR: r = a ^ ~b;
    ADD:  r = a + b;
    SUB:  r = a - b;
    SLL:  r = a << b[4:0];
    SRL:  r = a >> b[4:0];
    SRA:  r = $signed(a) >>> b[4:0];
    SLTS: r = {31'd0, $signed(a) < $signed(b)};
    SLTU: r = {31'd0, a < b};
    default: r = model_simd(o, a, b);
  endcase
  return r;
endfunction

function automatic logic model_taken(alu_op_e o, logic [31:0] a, logic [31:0] b);
  case (o)
    EQ:      return a == b;
    NE:      return a != b;
    LTS:     return $signed(a) < $signed(b);
    LTU:     return a < b;
    GES:     return $signed(a) >= $signed(b);
    GEU:     return a >= b;
    default: return 1'b1;
  endcase
endfunction

// ----------------------------------------------------------------------
// Drive one item on the falling edge and check it one cycle later
// ----------------------------------------------------------------------
task automatic step_item(input logic v, input alu_op_e o, input logic [31:0] a,
                         input logic [31:0] b, input logic chk_res);
  valid     = v;
  op        = o;
  operand_a = a;
  operand_b = b;
  if (v) begin
    exp_branch = model_taken(o, a, b);
    if (chk_res) exp_result = model_result(o, a, b);
  end
  @(negedge clk);
  check_value("valid_o", 32'(valid_out), 32'(v));
  if (chk_res || !v) check_value("result_o", result, exp_result);
  check_value("branch_res_o", 32'(branch_res), 32'(exp_branch));
endtask

// Random items on a range of operation codes
task automatic random_items(input int first, input int last, input logic chk_res);
  logic [31:0] a;
  logic [31:0] b;
  for (int c = first; c <= last; c++) begin
    for (int i = 0; i < N_RAND; i++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      step_item(1'b1, op_code(c), a, b, chk_res || (c == 11) || (c == 12));
    end
  end
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------

// ANDL through SUB
task automatic test_logic_arith();
  random_items(0, 7, 1'b1);
endtask

task automatic test_shifts();
  logic [31:0] a;
  logic [31:0] b;
  random_items(8, 10, 1'b1);
  for (int c = 8; c <= 10; c++) begin
    // Negative a shows the SRA sign fill
    a = rand_bits(32) | 32'h8000_0000;
    b = rand_bits(27) << 5;
    step_item(1'b1, op_code(c), a, b, 1'b1);
    b = (rand_bits(27) << 5) | 32'd31;
    step_item(1'b1, op_code(c), a, b, 1'b1);
  end
endtask

// SLTS and SLTU check the result, branches only the flag
task automatic test_compare();
  logic chk;
  alu_op_e o;
  random_items(11, 18, 1'b0);
  for (int c = 11; c <= 18; c++) begin
    o   = op_code(c);
    chk = (o == SLTS) || (o == SLTU);
    step_item(1'b1, o, 32'h1234_5678, 32'h1234_5678, chk);
    step_item(1'b1, o, 32'h8000_0000, 32'h7fff_ffff, chk);
    step_item(1'b1, o, 32'h7fff_ffff, 32'h8000_0000, chk);
    step_item(1'b1, o, 32'hffff_ffff, 32'h0000_0000, chk);
    step_item(1'b1, o, 32'h0000_0000, 32'hffff_ffff, chk);
  end
endtask

task automatic test_simd_wrap();
  random_items(19, 22, 1'b1);
  // Every lane carries out, nothing may cross
  for (int c = 19; c <= 22; c++) begin
    step_item(1'b1, op_code(c), 32'hffff_ffff, 32'h0101_0101, 1'b1);
  end
endtask

task automatic test_simd_halving();
  random_items(23, 30, 1'b1);
  for (int c = 23; c <= 30; c++) begin
    step_item(1'b1, op_code(c), 32'h7f7f_7fff, 32'h7f7f_7fff, 1'b1);
    step_item(1'b1, op_code(c), 32'h8080_8000, 32'h7f7f_7fff, 1'b1);
  end
endtask

// Back-to-back items of both kinds with gaps
task automatic test_streaming();
  logic        v;
  logic [4:0]  idx;
  logic [31:0] a;
  logic [31:0] b;
  for (int i = 0; i < N_STREAM; i++) begin
    v   = (i == 0) || (rand_bits(2) != 2'd0);
    idx = 5'(rand_bits(5) % 32'd25);
    a   = rand_bits(32);
    b   = rand_bits(32);
    // Skip the branch codes 13 to 18
    step_item(v, op_code((idx < 5'd13) ? int'(idx) : int'(idx) + 6), a, b, 1'b1);
  end
endtask

task automatic test_mid_reset();
  logic [31:0] a;
  logic [31:0] b;
  rst       = 1'b1;
  valid     = 1'b1;
  op        = ADD;
  operand_a = rand_bits(32);
  operand_b = rand_bits(32);
  repeat (3) begin
    @(negedge clk);
    check_value("valid_o", 32'(valid_out), 32'd0);
    check_value("result_o", result, 32'd0);
  end
  rst        = 1'b0;
  valid      = 1'b0;
  exp_result = '0;
  @(negedge clk);
  check_value("valid_o", 32'(valid_out), 32'd0);
  check_value("result_o", result, 32'd0);
  for (int i = 0; i < 4; i++) begin
    a = rand_bits(32);
    b = rand_bits(32);
    step_item(1'b1, (i % 2 == 0) ? ADD16 : XORL, a, b, 1'b1);
  end
endtask

`endif

/* test/tb_alu.sv */
`timescale 1ns/10ps

module tb_alu
  import alu_pkg::*;
();

  // Random items per operation in the directed tests
  localparam int N_RAND   = 40;
  localparam int N_STREAM = 200;

  // Items of logic, shifts, compares, wrapping SIMD, halving SIMD, stream and reset
  localparam int TOTAL_ITEMS = 8 * N_RAND + 3 * (N_RAND + 2) + 8 * (N_RAND + 5)
                             + 4 * (N_RAND + 1) + 8 * (N_RAND + 2) + N_STREAM + 8;
  // Twice the items at two cycles each, plus the reset
  localparam int CYCLE_LIMIT = 2 * (TOTAL_ITEMS * 2) + 16;

  logic            clk;
  logic            rst;
  logic            valid;
  alu_op_e         op;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic            valid_out;
  logic [XLEN-1:0] result;
  logic            branch_res;

  // LFSR state and the expected output register contents
  logic [31:0]     lfsr_state;
  logic [XLEN-1:0] exp_result;
  logic            exp_branch;
  int unsigned     cycle_count = 0;

  alu_top dut_i (
    .clk_i        (clk),
    .rst_i        (rst),
    .valid_i      (valid),
    .op_i         (op),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .valid_o      (valid_out),
    .result_o     (result),
    .branch_res_o (branch_res)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  `include "tb_alu_tasks.svh"

  // ----------------------------------------------------------------------
  // Timeout
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("tests failed");
      $fatal(1, "simulation timed out");
    end
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    valid      = 1'b0;
    op         = ADD;
    operand_a  = '0;
    operand_b  = '0;
    lfsr_state = 32'h86f;
    exp_result = '0;
    exp_branch = 1'b0;

    repeat (16) @(negedge clk);
    // Output register is empty and cleared by reset
    check_value("valid_o", 32'(valid_out), 32'd0);
    check_value("result_o", result, 32'd0);
    rst = 1'b0;

    test_logic_arith();
    test_shifts();
    test_compare();
    test_simd_wrap();
    test_simd_halving();
    test_streaming();
    test_mid_reset();

    valid = 1'b0;
    @(negedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

/* rtl/alu_top.sv */
`timescale 1ns/10ps

module alu_top
  import alu_pkg::*;
  import simd_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            valid_i,
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic            valid_o,
  output logic [XLEN-1:0] result_o,
  output logic            branch_res_o
);

  logic [XLEN-1:0] scalar_result;
  logic            cmp_taken;

  lane_ext_t lane_a [NUM_LANES];
  lane_ext_t lane_b [NUM_LANES];
  lane_ext_t lane_sum [NUM_LANES];
  logic [NUM_LANES-1:0] lane_carry;  // carry into each lane
  logic negate;
  logic vsize;
  logic halving;
  logic [XLEN-1:0] simd_result;

  scalar_alu u_scalar_alu (
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (scalar_result),
    .taken_o     (cmp_taken)
  );

  // ----------------------------------------------------------------------
  // SIMD adder lanes
  // ----------------------------------------------------------------------
  simd_lane_ctrl u_simd_lane_ctrl (
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .lane_a_o    (lane_a),
    .lane_b_o    (lane_b),
    .negate_o    (negate),
    .vsize_o     (vsize),
    .halving_o   (halving)
  );

  // Lowest lane never takes a chained carry
  assign lane_carry[0] = 1'b0;

  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lane
    if (k < NUM_LANES - 1) begin : gen_chained
      simd_lane_adder #(
        .UPPER_HALF (k % 2 == 1)
      ) u_lane_adder (
        .lane_a_i (lane_a[k]),
        .lane_b_i (lane_b[k]),
        .negate_i (negate),
        .vsize_i  (vsize),
        .carry_i  (lane_carry[k]),
        .sum_o    (lane_sum[k]),
        .carry_o  (lane_carry[k+1])
      );
    end else begin : gen_top_lane
      // Carry out of the top lane leaves the word
      simd_lane_adder #(
        .UPPER_HALF (k % 2 == 1)
      ) u_lane_adder (
        .lane_a_i (lane_a[k]),
        .lane_b_i (lane_b[k]),
        .negate_i (negate),
        .vsize_i  (vsize),
        .carry_i  (lane_carry[k]),
        .sum_o    (lane_sum[k]),
        .carry_o  ()
      );
    end
  end

  simd_lane_pack u_simd_lane_pack (
    .sum_i     (lane_sum),
    .vsize_i   (vsize),
    .halving_i (halving),
    .result_o  (simd_result)
  );

  alu_result_stage u_result_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .valid_i      (valid_i),
    .op_i         (op_i),
    .scalar_i     (scalar_result),
    .simd_i       (simd_result),
    .taken_i      (cmp_taken),
    .valid_o      (valid_o),
    .result_o     (result_o),
    .branch_res_o (branch_res_o)
  );

endmodule

/* rtl/alu_result_stage.sv */
`timescale 1ns/10ps

module alu_result_stage
  import alu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            valid_i,
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] scalar_i,
  input  logic [XLEN-1:0] simd_i,
  input  logic            taken_i,
  output logic            valid_o,
  output logic [XLEN-1:0] result_o,
  output logic            branch_res_o
);

  logic [XLEN-1:0] result_d;

  // Operation class picks the source unit
  assign result_d = is_simd_op(op_i) ? simd_i : scalar_i;

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o      <= 1'b0;
      result_o     <= '0;
      branch_res_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      // Hold last item across gaps
      if (valid_i) begin
        result_o     <= result_d;
        branch_res_o <= taken_i;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  // Output side is empty and cleared right after reset
  reset_clears_out_a: assert property (
    @(posedge clk_i) rst_i |=> (!valid_o && (result_o == '0))
  ) else $error("valid_o or result_o not cleared after reset");

  // One cycle of latency on the valid flag
  valid_latency_a: assert property (
    @(posedge clk_i) !rst_i |=> (valid_o == $past(valid_i))
  ) else $error("valid_o does not follow valid_i by one cycle");

  // URSUB16 is the last code in the encoding
  op_known_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    valid_i |-> (!$isunknown(op_i) && (op_i <= URSUB16))
  ) else $error("unknown operation code %0d with valid_i", op_i);

endmodule

/* rtl/scalar_alu.sv */
`timescale 1ns/10ps

module scalar_alu
  import alu_pkg::*;
(
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] result_o,
  output logic            taken_o
);

  logic            negate_b;
  logic [XLEN:0]   operand_b_neg;
  logic [XLEN:0]   adder_sum;
  logic [XLEN-1:0] adder_result;
  logic            adder_zero;
  logic            less;

  logic            shift_left;
  logic            shift_arith;
  logic [XLEN-1:0] operand_a_rev;
  logic [XLEN-1:0] shift_op_a;
  logic [XLEN:0]   shift_right_ext;
  logic [XLEN-1:0] shift_left_res;
  logic [XLEN-1:0] shift_result;

  // ----------------------------------------------------------------------
  // Adder, shared by add, subtract, equality and the N logic forms
  // ----------------------------------------------------------------------
  always_comb begin
    case (op_i)
      SUB, EQ, NE, ANDN, ORN, XNOR: negate_b = 1'b1;
      default:                      negate_b = 1'b0;
    endcase
  end

  // Low bit of one on a turns the inverted b into a two's complement
  assign operand_b_neg = {operand_b_i, 1'b0} ^ {(XLEN + 1){negate_b}};
  assign adder_sum     = {operand_a_i, 1'b1} + operand_b_neg;
  assign adder_result  = adder_sum[XLEN:1];
  assign adder_zero    = ~|adder_result;

  // Signed or unsigned compare on a 33-bit extension
  always_comb begin
    logic sgn;
    sgn  = (op_i == SLTS) || (op_i == LTS) || (op_i == GES);
    less = $signed({sgn & operand_a_i[XLEN-1], operand_a_i}) <
           $signed({sgn & operand_b_i[XLEN-1], operand_b_i});
  end

  // Branch resolution
  always_comb begin
    case (op_i)
      EQ:       taken_o = adder_zero;
      NE:       taken_o = ~adder_zero;
      LTS, LTU: taken_o = less;
      GES, GEU: taken_o = ~less;
      default:  taken_o = 1'b1;
    endcase
  end

  // ----------------------------------------------------------------------
  // Shifter, left shifts run through the right shifter bit reversed
  // ----------------------------------------------------------------------
  assign shift_left  = (op_i == SLL);
  assign shift_arith = (op_i == SRA);

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      operand_a_rev[i]  = operand_a_i[XLEN-1-i];
      shift_left_res[i] = shift_right_ext[XLEN-1-i];
    end
  end

  assign shift_op_a      = shift_left ? operand_a_rev : operand_a_i;
  assign shift_right_ext = $unsigned($signed({shift_arith & shift_op_a[XLEN-1], shift_op_a})
                                     >>> operand_b_i[SHAMT_W-1:0]);
  assign shift_result    = shift_left ? shift_left_res : shift_right_ext[XLEN-1:0];

  // Result mux, SIMD codes leave zero here
  always_comb begin
    case (op_i)
      ANDL, ANDN:    result_o = operand_a_i & operand_b_neg[XLEN:1];
      ORL, ORN:      result_o = operand_a_i | operand_b_neg[XLEN:1];
      XORL, XNOR:    result_o = operand_a_i ^ operand_b_neg[XLEN:1];
      ADD, SUB:      result_o = adder_result;
      SLL, SRL, SRA: result_o = shift_result;
      SLTS, SLTU:    result_o = {{(XLEN - 1){1'b0}}, less};
      default:       result_o = '0;
    endcase
  end

endmodule

/* simd/simd_lane_pack.sv */
`timescale 1ns/10ps

module simd_lane_pack
  import simd_pkg::*;
(
  input  lane_ext_t                   sum_i [NUM_LANES],
  input  logic                        vsize_i,
  input  logic                        halving_i,
  output logic [NUM_LANES*LANE_W-1:0] result_o
);

  simd_word_u packed_word;

  // ----------------------------------------------------------------------
  // Per half: lanes 2h (lower byte) and 2h+1 (upper byte)
  // ----------------------------------------------------------------------
  always_comb begin
    lane_ext_t lo;
    lane_ext_t hi;
    for (int h = 0; h < NUM_LANES / 2; h++) begin
      lo = sum_i[2*h];
      hi = sum_i[2*h+1];
      if (!halving_i) begin
        // Wrapping result
        packed_word.lanes[2*h]   = lo[LANE_W-1:0];
        packed_word.lanes[2*h+1] = hi[LANE_W-1:0];
      end else if (!vsize_i) begin
        // Each byte shifted down by one
        packed_word.lanes[2*h]   = lo[LANE_W:1];
        packed_word.lanes[2*h+1] = hi[LANE_W:1];
      end else begin
        // 17-bit half sum shifted down, hi bit 0 drops into the lower byte
        packed_word.lanes[2*h]   = {hi[0], lo[LANE_W-1:1]};
        packed_word.lanes[2*h+1] = hi[LANE_W:1];
      end
    end
  end

  assign result_o = packed_word.word;

endmodule

/* simd/simd_lane_adder.sv */
`timescale 1ns/10ps

module simd_lane_adder
  import simd_pkg::*;
#(
  // Set on lanes holding the upper byte of a 16-bit half
  parameter bit UPPER_HALF = 1'b0
) (
  input  lane_ext_t lane_a_i,
  input  lane_ext_t lane_b_i,
  input  logic      negate_i,
  input  logic      vsize_i,
  input  logic      carry_i,
  output lane_ext_t sum_o,
  output logic      carry_o
);

  logic lane_cin;

  // Carry-in select
  if (UPPER_HALF) begin : gen_upper
    // Chained from the lower byte in 16-bit mode
    assign lane_cin = vsize_i ? carry_i : negate_i;
  end else begin : gen_lower
    assign lane_cin = negate_i;
  end

  assign sum_o   = lane_a_i + lane_b_i + lane_ext_t'(lane_cin);
  assign carry_o = sum_o[LANE_W];

endmodule

/* simd/simd_lane_ctrl.sv */
`timescale 1ns/10ps

module simd_lane_ctrl
  import alu_pkg::*;
  import simd_pkg::*;
(
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output lane_ext_t       lane_a_o [NUM_LANES],
  output lane_ext_t       lane_b_o [NUM_LANES],
  output logic            negate_o,
  output logic            vsize_o,
  output logic            halving_o
);

  simd_word_u word_a;
  simd_word_u word_b;
  logic       sext;

  assign word_a.word = operand_a_i;
  assign word_b.word = operand_b_i;

  // ----------------------------------------------------------------------
  // Operation decode
  // ----------------------------------------------------------------------
  always_comb begin
    vsize_o   = 1'b0;
    sext      = 1'b0;
    negate_o  = 1'b0;
    halving_o = 1'b0;
    case (op_i)
      ADD8:    ;
      SUB8:    negate_o = 1'b1;
      ADD16:   vsize_o = 1'b1;
      SUB16: begin
        vsize_o  = 1'b1;
        negate_o = 1'b1;
      end
      // Signed halving forms
      RADD8, RSUB8, RADD16, RSUB16: begin
        sext      = 1'b1;
        halving_o = 1'b1;
        negate_o  = (op_i == RSUB8) || (op_i == RSUB16);
        vsize_o   = (op_i == RADD16) || (op_i == RSUB16);
      end
      // Unsigned halving forms
      URADD8, URSUB8, URADD16, URSUB16: begin
        halving_o = 1'b1;
        negate_o  = (op_i == URSUB8) || (op_i == URSUB16);
        vsize_o   = (op_i == URADD16) || (op_i == URSUB16);
      end
      default: ;
    endcase
  end

  // Extended lane operands
  always_comb begin
    logic ext_a;
    logic ext_b;
    logic keep_ext;
    for (int k = 0; k < NUM_LANES; k++) begin
      ext_a = word_a.lanes[k][LANE_W-1] & sext;
      ext_b = word_b.lanes[k][LANE_W-1] & sext;
      // Lower byte of a 16-bit half must carry out cleanly at bit 8
      keep_ext = (k % 2 == 1) || !vsize_o;
      lane_a_o[k] = {ext_a & keep_ext, word_a.lanes[k]};
      lane_b_o[k] = {(ext_b ^ negate_o) & keep_ext,
                     word_b.lanes[k] ^ {LANE_W{negate_o}}};
    end
  end

  // Lane controls stay idle outside the SIMD class used by the result stage
  always_comb begin
    simd_ctrl_class_a: assert ((!vsize_o && !negate_o && !halving_o) || is_simd_op(op_i))
      else $error("SIMD lane control active for scalar operation %0d", op_i);
  end

endmodule

/* common/simd_pkg.sv */
package simd_pkg;

  // Byte lane layout of the packed SIMD adder
  localparam int NUM_LANES = 4;
  localparam int LANE_W    = 8;

  // Lane operand with one extension bit above the byte
  typedef logic [LANE_W:0] lane_ext_t;

  // ----------------------------------------------------------------------
  // Operand word, seen either as one word or as its byte lanes
  // ----------------------------------------------------------------------
  typedef union packed {
    logic [NUM_LANES*LANE_W-1:0]      word;
    logic [NUM_LANES-1:0][LANE_W-1:0] lanes;
  } simd_word_u;

endpackage

/* common/alu_pkg.sv */
package alu_pkg;

  // Data word and shift amount widths
  localparam int XLEN    = 32;
  localparam int SHAMT_W = 5;

  // Operation codes, one per kept operation
  typedef enum logic [4:0] {
    // Scalar logic, N forms take inverted operand b
    ANDL, ORL, XORL,
    ANDN, ORN, XNOR,
    // Scalar arithmetic and shifts
    ADD, SUB,
    SLL, SRL, SRA,
    // Set-less-than and branch resolution
    SLTS, SLTU,
    EQ, NE, LTS, LTU, GES, GEU,
    // Packed SIMD, wrapping
    ADD8, SUB8, ADD16, SUB16,
    // Packed SIMD, halving
    RADD8, RSUB8, URADD8, URSUB8,
    RADD16, RSUB16, URADD16, URSUB16
  } alu_op_e;

  // Operation class decode, true for the SIMD adder group
  function automatic logic is_simd_op(alu_op_e op);
    logic simd;
    case (op)
      ADD8, SUB8, ADD16, SUB16,
      RADD8, RSUB8, URADD8, URSUB8,
      RADD16, RSUB16, URADD16, URSUB16: simd = 1'b1;
      default:                          simd = 1'b0;
    endcase
    return simd;
  endfunction

endpackage
